// File: hl2_pkg.sv
// Hermes-Lite 2 shared definitions
// Host register addresses, timing and level constants, and the packed
// structs that carry commands and samples between the core blocks
`default_nettype none

package hl2_pkg;

  // Host register addresses
  localparam logic [5:0] ADDR_TR     = 6'h00;
  localparam logic [5:0] ADDR_CONFIG = 6'h09;
  localparam logic [5:0] ADDR_HANG   = 6'h11;
  localparam logic [5:0] ADDR_AD9866 = 6'h3B;

  // Cycles from T/R relay closed to TX enabled
  localparam int TX_DELAY = 8;
  // Clock cycles per half period of the AD9866 serial clock
  localparam int SPI_HALF = 2;
  // Cycles an overload LED stays lit after its last trigger
  localparam int LED_HOLD = 256;
  // Magnitude thresholds for the 12-bit ADC
  localparam int ADC_75   = 1536;
  localparam int ADC_FULL = 2047;

  typedef struct packed {
    logic        valid;
    logic [5:0]  addr;
    logic [31:0] data;
  } host_cmd_t;

  typedef struct packed {
    logic        mox;
    logic        pa_enable;
    logic [15:0] hang;
  } tr_cfg_t;

  typedef struct packed {
    logic       start;
    logic [5:0] addr;
    logic [7:0] data;
  } spi_req_t;

  typedef struct packed {
    logic               valid;
    logic signed [11:0] sample;
  } adc_sample_t;

endpackage

`default_nettype wire

// File: cmd_regs.sv
// Host command register file
// Decodes host command words into the T/R configuration, the AD9866
// reset line and single-cycle AD9866 SPI write requests
`default_nettype none

module cmd_regs import hl2_pkg::*; (
  input  logic      clk_ad9866,
  input  logic      reset,
  input  host_cmd_t host_cmd,
  input  logic      spi_busy,
  output tr_cfg_t   tr_cfg,
  output spi_req_t  spi_req,
  output logic      rffe_ad9866_rst_n
);

  logic        mox_q;
  logic        pa_enable_q;
  logic        ad9866_reset_q;
  logic [15:0] hang_q;
  logic        start_q;
  logic [5:0]  spi_addr_q;
  logic [7:0]  spi_data_q;
  logic        wr_ad9866;

  // A write to the AD9866 address is only taken when the SPI writer is idle
  assign wr_ad9866 = host_cmd.valid && (host_cmd.addr == ADDR_AD9866) && !spi_busy;

  always_ff @(posedge clk_ad9866) begin
    if (reset) begin
      mox_q          <= 1'b0;
      pa_enable_q    <= 1'b0;
      ad9866_reset_q <= 1'b0;
      hang_q         <= 16'd0;
      start_q        <= 1'b0;
    end else begin
      start_q <= wr_ad9866;
      if (host_cmd.valid) begin
        case (host_cmd.addr)
          ADDR_TR:     mox_q <= host_cmd.data[0];
          ADDR_CONFIG: begin
            pa_enable_q    <= host_cmd.data[0];
            ad9866_reset_q <= host_cmd.data[1];
          end
          ADDR_HANG:   hang_q <= host_cmd.data[15:0];
          default:     ;
        endcase
      end
    end
  end

  // Register address and data captured with the accepted write
  always_ff @(posedge clk_ad9866) begin
    if (wr_ad9866) begin
      spi_addr_q <= host_cmd.data[13:8];
      spi_data_q <= host_cmd.data[7:0];
    end
  end

  assign tr_cfg            = '{mox: mox_q, pa_enable: pa_enable_q, hang: hang_q};
  assign spi_req           = '{start: start_q, addr: spi_addr_q, data: spi_data_q};
  assign rffe_ad9866_rst_n = ~ad9866_reset_q;

  // Busy from the SPI writer covers the start cycle, so back-to-back writes collapse
  a_start_single: assert property (@(posedge clk_ad9866) disable iff (reset)
    spi_req.start |=> !spi_req.start);

endmodule

`default_nettype wire

// File: tr_sequencer.sv
// Transmit/receive sequencer
// Combines host MOX and the CW key into a transmit request, closes the
// T/R relay first, enables TX and the PA after a fixed delay, and holds
// the relay closed for a programmable hang time after key up
`default_nettype none

module tr_sequencer import hl2_pkg::*; (
  input  logic    clk_ad9866,
  input  logic    reset,
  input  tr_cfg_t tr_cfg,
  input  logic    io_phone_tip,
  input  logic    io_tx_inhibit,
  output logic    pa_inttr,
  output logic    pwr_envbias,
  output logic    rffe_rfsw_sel,
  output logic    rffe_ad9866_txquiet_n,
  output logic    io_led_tx
);

  typedef enum logic [1:0] {RX, KEYDOWN_DELAY, TX, HANG} tr_state_t;

  tr_state_t   state;
  tr_state_t   state_next;
  logic [15:0] count;
  logic [15:0] count_next;
  logic [1:0]  key_sync;
  logic [1:0]  inhibit_sync;
  logic        tx_req;

  // Both pins are asynchronous to the AD9866 clock
  always_ff @(posedge clk_ad9866) begin
    if (reset) begin
      key_sync     <= 2'b11;
      inhibit_sync <= 2'b00;
    end else begin
      key_sync     <= {key_sync[0], io_phone_tip};
      inhibit_sync <= {inhibit_sync[0], io_tx_inhibit};
    end
  end

  assign tx_req = (tr_cfg.mox | ~key_sync[1]) & ~inhibit_sync[1];

  // One down-counter serves the keydown delay and the hang time
  always_comb begin
    state_next = state;
    count_next = count;
    case (state)
      RX: if (tx_req) begin
        state_next = KEYDOWN_DELAY;
        count_next = 16'(TX_DELAY - 1);
      end
      KEYDOWN_DELAY: if (count == 16'd0) state_next = TX;
                     else count_next = count - 16'd1;
      TX: if (!tx_req) begin
        if (tr_cfg.hang == 16'd0) begin
          state_next = RX;
        end else begin
          state_next = HANG;
          count_next = tr_cfg.hang - 16'd1;
        end
      end
      HANG: if (tx_req) state_next = TX;
            else if (count == 16'd0) state_next = RX;
            else count_next = count - 16'd1;
      default: state_next = RX;
    endcase
    if (inhibit_sync[1]) state_next = RX;
  end

  always_ff @(posedge clk_ad9866) begin
    if (reset) begin
      state                 <= RX;
      count                 <= 16'd0;
      pa_inttr              <= 1'b0;
      rffe_rfsw_sel         <= 1'b0;
      rffe_ad9866_txquiet_n <= 1'b0;
      io_led_tx             <= 1'b0;
      pwr_envbias           <= 1'b0;
    end else begin
      state                 <= state_next;
      count                 <= count_next;
      pa_inttr              <= (state_next != RX);
      rffe_rfsw_sel         <= (state_next != RX);
      rffe_ad9866_txquiet_n <= (state_next == TX);
      io_led_tx             <= (state_next == TX);
      pwr_envbias           <= (state_next == TX) && tr_cfg.pa_enable;
    end
  end

  // The relay must be closed for the whole keydown delay before the PA or TX comes on
  a_pa_needs_tr: assert property (@(posedge clk_ad9866) disable iff (reset)
    pwr_envbias |-> $past(pa_inttr, TX_DELAY));
  a_tx_needs_sw: assert property (@(posedge clk_ad9866) disable iff (reset)
    rffe_ad9866_txquiet_n |-> $past(rffe_rfsw_sel, TX_DELAY));

endmodule

`default_nettype wire

// File: ad9866_spi.sv
// AD9866 SPI register writer
// Sends one 16-bit write frame per start pulse, MSB first, with a write
// bit and a reserved bit ahead of the 6-bit address and 8-bit data.
// Data changes while sclk is low and sclk rises in the middle of each bit
`default_nettype none

module ad9866_spi import hl2_pkg::*; (
  input  logic     clk_ad9866,
  input  logic     reset,
  input  spi_req_t spi_req,
  output logic     spi_busy,
  output logic     rffe_ad9866_sen_n,
  output logic     rffe_ad9866_sclk,
  output logic     rffe_ad9866_sdio
);

  logic        active;
  logic [3:0]  half_cnt;
  logic [4:0]  bit_cnt;
  logic [15:0] shreg;
  logic [15:0] frame;

  assign frame    = {1'b0, 1'b0, spi_req.addr, spi_req.data};
  assign spi_busy = spi_req.start | active;

  always_ff @(posedge clk_ad9866) begin
    if (reset) begin
      active            <= 1'b0;
      half_cnt          <= 4'd0;
      bit_cnt           <= 5'd0;
      rffe_ad9866_sen_n <= 1'b1;
      rffe_ad9866_sclk  <= 1'b0;
      rffe_ad9866_sdio  <= 1'b0;
    end else if (spi_req.start) begin
      active            <= 1'b1;
      half_cnt          <= 4'd0;
      bit_cnt           <= 5'd0;
      rffe_ad9866_sen_n <= 1'b0;
      rffe_ad9866_sclk  <= 1'b0;
      rffe_ad9866_sdio  <= frame[15];
    end else if (active) begin
      if (bit_cnt == 5'd16) begin
        // One idle cycle after the last falling edge before deselect
        active            <= 1'b0;
        rffe_ad9866_sen_n <= 1'b1;
        rffe_ad9866_sdio  <= 1'b0;
      end else if (half_cnt == 4'(SPI_HALF - 1)) begin
        half_cnt         <= 4'd0;
        rffe_ad9866_sclk <= ~rffe_ad9866_sclk;
        if (rffe_ad9866_sclk) begin
          bit_cnt          <= bit_cnt + 5'd1;
          rffe_ad9866_sdio <= shreg[14];
        end
      end else begin
        half_cnt <= half_cnt + 4'd1;
      end
    end
  end

  // Shift register advances on each falling sclk edge
  always_ff @(posedge clk_ad9866) begin
    if (spi_req.start) begin
      shreg <= frame;
    end else if (active && half_cnt == 4'(SPI_HALF - 1) && rffe_ad9866_sclk) begin
      shreg <= {shreg[14:0], 1'b0};
    end
  end

  // The register file must hold off new writes while a frame is on the wire
  a_no_start_busy: assert property (@(posedge clk_ad9866) disable iff (reset)
    spi_req.start |-> !active);

endmodule

`default_nettype wire

// File: adc_overload.sv
// ADC overload detector
// Pairs the two 6-bit AD9866 receive nibbles into 12-bit samples and
// lights the 75% and full-scale LEDs, each held for a fixed time after
// the last sample that crossed its level
`default_nettype none

module adc_overload import hl2_pkg::*; (
  input  logic       clk_ad9866,
  input  logic       reset,
  input  logic [5:0] rffe_ad9866_rx,
  input  logic       rffe_ad9866_rxsync,
  output logic       io_led_adc75,
  output logic       io_led_adc100
);

  adc_sample_t sample;
  logic [5:0]  rx_hi;
  logic        hi_valid;
  logic [11:0] mag;
  logic [8:0]  cnt75;
  logic [8:0]  cnt100;

  // The rxsync cycle carries the upper half of the sample
  always_ff @(posedge clk_ad9866) begin
    if (reset) begin
      hi_valid     <= 1'b0;
      sample.valid <= 1'b0;
    end else begin
      sample.valid <= 1'b0;
      if (rffe_ad9866_rxsync) begin
        rx_hi    <= rffe_ad9866_rx;
        hi_valid <= 1'b1;
      end else if (hi_valid) begin
        sample.valid  <= 1'b1;
        sample.sample <= {rx_hi, rffe_ad9866_rx};
        hi_valid      <= 1'b0;
      end
    end
  end

  // Negating -2048 wraps to 12'h800, which reads as 2048 unsigned
  assign mag = sample.sample[11] ? 12'(-sample.sample) : 12'(sample.sample);

  always_ff @(posedge clk_ad9866) begin
    if (reset) begin
      cnt75  <= 9'd0;
      cnt100 <= 9'd0;
    end else begin
      if (sample.valid && mag >= 12'(ADC_75)) cnt75 <= 9'(LED_HOLD);
      else if (cnt75 != 9'd0) cnt75 <= cnt75 - 9'd1;
      if (sample.valid && (sample.sample == 12'(ADC_FULL) ||
                           sample.sample == 12'(-ADC_FULL - 1))) cnt100 <= 9'(LED_HOLD);
      else if (cnt100 != 9'd0) cnt100 <= cnt100 - 9'd1;
    end
  end

  assign io_led_adc75  = (cnt75 != 9'd0);
  assign io_led_adc100 = (cnt100 != 9'd0);

endmodule

`default_nettype wire

// File: hermeslite_core.sv
// Hermes-Lite 2 core
// Host command registers, T/R sequencing, AD9866 configuration over SPI
// and ADC overload indication, all on the AD9866 clock
`default_nettype none

module hermeslite_core import hl2_pkg::*; (
  input  logic       clk_ad9866,
  input  logic       reset,
  input  host_cmd_t  host_cmd,
  input  logic [5:0] rffe_ad9866_rx,
  input  logic       rffe_ad9866_rxsync,
  input  logic       io_tx_inhibit,
  input  logic       io_phone_tip,
  output logic       rffe_ad9866_rst_n,
  output logic       rffe_ad9866_sdio,
  output logic       rffe_ad9866_sclk,
  output logic       rffe_ad9866_sen_n,
  output logic       rffe_ad9866_txquiet_n,
  output logic       rffe_rfsw_sel,
  output logic       io_led_tx,
  output logic       io_led_adc75,
  output logic       io_led_adc100,
  output logic       pa_inttr,
  output logic       pwr_envbias
);

  tr_cfg_t  tr_cfg;
  spi_req_t spi_req;
  logic     spi_busy;

  cmd_regs cmd_regs_i (
    .clk_ad9866       (clk_ad9866       ),
    .reset            (reset            ),
    .host_cmd         (host_cmd         ),
    .spi_busy         (spi_busy         ),
    .tr_cfg           (tr_cfg           ),
    .spi_req          (spi_req          ),
    .rffe_ad9866_rst_n(rffe_ad9866_rst_n)
  );

  tr_sequencer tr_sequencer_i (
    .clk_ad9866           (clk_ad9866           ),
    .reset                (reset                ),
    .tr_cfg               (tr_cfg               ),
    .io_phone_tip         (io_phone_tip         ),
    .io_tx_inhibit        (io_tx_inhibit        ),
    .pa_inttr             (pa_inttr             ),
    .pwr_envbias          (pwr_envbias          ),
    .rffe_rfsw_sel        (rffe_rfsw_sel        ),
    .rffe_ad9866_txquiet_n(rffe_ad9866_txquiet_n),
    .io_led_tx            (io_led_tx            )
  );

  ad9866_spi ad9866_spi_i (
    .clk_ad9866       (clk_ad9866       ),
    .reset            (reset            ),
    .spi_req          (spi_req          ),
    .spi_busy         (spi_busy         ),
    .rffe_ad9866_sen_n(rffe_ad9866_sen_n),
    .rffe_ad9866_sclk (rffe_ad9866_sclk ),
    .rffe_ad9866_sdio (rffe_ad9866_sdio )
  );

  adc_overload adc_overload_i (
    .clk_ad9866        (clk_ad9866        ),
    .reset             (reset             ),
    .rffe_ad9866_rx    (rffe_ad9866_rx    ),
    .rffe_ad9866_rxsync(rffe_ad9866_rxsync),
    .io_led_adc75      (io_led_adc75      ),
    .io_led_adc100     (io_led_adc100     )
  );

endmodule

`default_nettype wire

// File: hermeslite.sv
// Hermes-Lite 2 board top
// Maps the board pin names onto the functional ports of the core
`default_nettype none

module hermeslite import hl2_pkg::*; (
  // RF frontend
  input  logic       rffe_ad9866_clk76p8  ,
  input  logic       reset                ,
  input  host_cmd_t  host_cmd             ,
  input  logic [5:0] rffe_ad9866_rx       ,
  input  logic       rffe_ad9866_rxsync   ,
  output logic       rffe_ad9866_rst_n    ,
  output logic       rffe_ad9866_sdio     ,
  output logic       rffe_ad9866_sclk     ,
  output logic       rffe_ad9866_sen_n    ,
  output logic       rffe_ad9866_txquiet_n,
  output logic       rffe_rfsw_sel        ,
  // IO
  input  logic       io_cn8               ,
  input  logic       io_phone_tip         ,
  output logic       io_led_d3            ,
  output logic       io_led_d4            ,
  output logic       io_led_d5            ,
  // PA
  output logic       pa_tr                ,
  output logic       pa_en
);

  hermeslite_core hermeslite_core_i (
    .clk_ad9866           (rffe_ad9866_clk76p8  ),
    .reset                (reset                ),
    .host_cmd             (host_cmd             ),
    .rffe_ad9866_rx       (rffe_ad9866_rx       ),
    .rffe_ad9866_rxsync   (rffe_ad9866_rxsync   ),
    .io_tx_inhibit        (io_cn8               ),
    .io_phone_tip         (io_phone_tip         ),
    .rffe_ad9866_rst_n    (rffe_ad9866_rst_n    ),
    .rffe_ad9866_sdio     (rffe_ad9866_sdio     ),
    .rffe_ad9866_sclk     (rffe_ad9866_sclk     ),
    .rffe_ad9866_sen_n    (rffe_ad9866_sen_n    ),
    .rffe_ad9866_txquiet_n(rffe_ad9866_txquiet_n),
    .rffe_rfsw_sel        (rffe_rfsw_sel        ),
    .io_led_tx            (io_led_d3            ),
    .io_led_adc75         (io_led_d4            ),
    .io_led_adc100        (io_led_d5            ),
    .pa_inttr             (pa_tr                ),
    .pwr_envbias          (pa_en                )
  );

endmodule

`default_nettype wire

// File: tb_hermeslite.sv
// Hermes-Lite 2 testbench
// Drives host commands, the CW key, TX inhibit and ADC nibbles into the
// board top and checks AD9866 SPI frames, T/R timing and overload LEDs
`default_nettype none

module tb_hermeslite import hl2_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int P_PA_TR = 0;
  localparam int P_TXQ   = 1;
  localparam int P_SEN_N = 2;
  localparam int P_LED75 = 3;

  logic        clk;
  logic        reset;
  host_cmd_t   host_cmd;
  logic [5:0]  rx;
  logic        rxsync;
  logic        io_cn8;
  logic        io_phone_tip;
  logic        rst_n;
  logic        sdio;
  logic        sclk;
  logic        sen_n;
  logic        txquiet_n;
  logic        rfsw_sel;
  logic        led_d3;
  logic        led_d4;
  logic        led_d5;
  logic        pa_tr;
  logic        pa_en;
  logic [31:0] rng;
  logic [15:0] spi_shift;
  int          spi_bits;

  hermeslite i_dut (
    .rffe_ad9866_clk76p8(clk), .reset(reset), .host_cmd(host_cmd),
    .rffe_ad9866_rx(rx), .rffe_ad9866_rxsync(rxsync),
    .rffe_ad9866_rst_n(rst_n), .rffe_ad9866_sdio(sdio), .rffe_ad9866_sclk(sclk),
    .rffe_ad9866_sen_n(sen_n), .rffe_ad9866_txquiet_n(txquiet_n),
    .rffe_rfsw_sel(rfsw_sel), .io_cn8(io_cn8), .io_phone_tip(io_phone_tip),
    .io_led_d3(led_d3), .io_led_d4(led_d4), .io_led_d5(led_d5),
    .pa_tr(pa_tr), .pa_en(pa_en)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // SPI monitor clears on frame select and shifts sdio in on each sclk rise
  always @(posedge sclk or negedge sen_n) begin
    if (!sclk) begin
      spi_shift = '0;
      spi_bits  = 0;
    end else if (!sen_n) begin
      spi_shift = {spi_shift[14:0], sdio};
      spi_bits  = spi_bits + 1;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Write bit and reserved bit are both zero ahead of address and data
  function automatic logic [15:0] spi_frame(input logic [5:0] a, input logic [7:0] d);
    return {1'b0, 1'b0, a, d};
  endfunction

  // Bit 1 is full scale, bit 0 is the 75% level
  function automatic logic [1:0] adc_class(input adc_sample_t s);
    int   mag;
    logic full;
    logic over;
    mag  = (s.sample < 0) ? -int'(s.sample) : int'(s.sample);
    full = s.valid && (int'(s.sample) == ADC_FULL || int'(s.sample) == -ADC_FULL - 1);
    over = s.valid && (mag >= ADC_75);
    return {full, over};
  endfunction

  // Cycles from relay closed to TX on, or from TX off to relay open
  function automatic int tr_interval(input logic keyup, input logic [15:0] hang);
    return keyup ? int'(hang) : TX_DELAY;
  endfunction

  function automatic logic pin(input int id);
    case (id)
      P_PA_TR: return pa_tr;
      P_TXQ:   return txquiet_n;
      P_SEN_N: return sen_n;
      default: return led_d4;
    endcase
  endfunction

  task automatic check_frame(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (expected !== actual) begin
      $display("Error: %s expected %h actual %h", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_level(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
      $display("Error: %s expected %b actual %b", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_cycles(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("Error: %s expected %0d actual %0d", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // Counts falling clock edges until the pin reaches the level
  task automatic wait_pin(input string what, input int id, input logic level,
                          input int limit, output int n);
    logic found;
    n     = 0;
    found = 1'b0;
    while (!found) begin
      @(negedge clk);
      n++;
      if (pin(id) === level) begin
        found = 1'b1;
      end else if (n >= limit) begin
        $display("Timeout: %s did not happen within %0d cycles", what, limit);
        $display("Simulation FAILED");
        $fatal(1);
      end
    end
  endtask

  task automatic write_cmd(input logic [5:0] a, input logic [31:0] d);
    @(posedge clk);
    host_cmd <= '{valid: 1'b1, addr: a, data: d};
    @(posedge clk);
    host_cmd <= '0;
  endtask

  task automatic drive_sample(input adc_sample_t s);
    @(posedge clk);
    rxsync <= 1'b1;
    rx     <= s.sample[11:6];
    @(posedge clk);
    rxsync <= 1'b0;
    rx     <= s.sample[5:0];
    @(posedge clk);
    rx     <= '0;
  endtask

  task automatic check_leds(input string name, input adc_sample_t s);
    logic [1:0] cls;
    int         n;
    cls = adc_class(s);
    drive_sample(s);
    repeat (2) @(negedge clk);
    check_level({name, " led_d4"}, cls[0], led_d4);
    check_level({name, " led_d5"}, cls[1], led_d5);
    // Both LEDs go dark again so the next sample starts from a known state
    if (cls != 2'b00) begin
      wait_pin({name, " led_d4 going dark"}, P_LED75, 1'b0, LED_HOLD + 4, n);
      check_level({name, " led_d5 dark"}, 1'b0, led_d5);
    end
  endtask

  initial begin
    int          n;
    int          mag;
    logic [15:0] hang;
    adc_sample_t s;
    reset        <= 1'b1;
    host_cmd     <= '0;
    rx           <= '0;
    rxsync       <= 1'b0;
    io_cn8       <= 1'b0;
    io_phone_tip <= 1'b1;
    rng = 32'h9c7e_50cd;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_level("reset pa_tr", 1'b0, pa_tr);
    check_level("reset pa_en", 1'b0, pa_en);
    check_level("reset rfsw_sel", 1'b0, rfsw_sel);
    check_level("reset txquiet_n", 1'b0, txquiet_n);
    check_level("reset sclk", 1'b0, sclk);
    check_level("reset sdio", 1'b0, sdio);
    check_level("reset led_d3", 1'b0, led_d3);
    check_level("reset led_d4", 1'b0, led_d4);
    check_level("reset led_d5", 1'b0, led_d5);
    check_level("reset sen_n", 1'b1, sen_n);
    check_level("reset rst_n", 1'b1, rst_n);
    write_cmd(ADDR_CONFIG, 32'd2);
    @(negedge clk);
    check_level("ad9866 reset on", 1'b0, rst_n);
    write_cmd(ADDR_CONFIG, 32'd0);
    @(negedge clk);
    check_level("ad9866 reset off", 1'b1, rst_n);

    for (int i = 0; i < 8; i++) begin
      rng = xorshift(rng);
      write_cmd(ADDR_AD9866, {18'd0, rng[13:0]});
      wait_pin("sen_n falling", P_SEN_N, 1'b0, 4, n);
      wait_pin("sen_n rising", P_SEN_N, 1'b1, 100, n);
      check_cycles("spi bit count", 16, spi_bits);
      check_frame("spi frame", spi_frame(rng[13:8], rng[7:0]), spi_shift);
    end

    rng  = xorshift(rng);
    hang = 16'(20 + rng % 41);
    write_cmd(ADDR_HANG, {16'd0, hang});
    write_cmd(ADDR_CONFIG, 32'd1);
    write_cmd(ADDR_TR, 32'd1);
    wait_pin("pa_tr rising on mox", P_PA_TR, 1'b1, 4, n);
    check_level("rfsw_sel on mox", 1'b1, rfsw_sel);
    check_level("pa_en before tx", 1'b0, pa_en);
    wait_pin("txquiet_n rising", P_TXQ, 1'b1, 40, n);
    check_cycles("mox keydown delay", tr_interval(1'b0, hang), n);
    check_level("pa_en with tx", 1'b1, pa_en);
    check_level("led_d3 with tx", 1'b1, led_d3);
    write_cmd(ADDR_TR, 32'd0);
    wait_pin("txquiet_n falling", P_TXQ, 1'b0, 4, n);
    check_level("pa_en at key up", 1'b0, pa_en);
    check_level("led_d3 at key up", 1'b0, led_d3);
    wait_pin("pa_tr falling after hang", P_PA_TR, 1'b0, 100, n);
    check_cycles("hang time", tr_interval(1'b1, hang), n);
    check_level("rfsw_sel after hang", 1'b0, rfsw_sel);
    write_cmd(ADDR_CONFIG, 32'd0);
    write_cmd(ADDR_TR, 32'd1);
    wait_pin("pa_tr rising", P_PA_TR, 1'b1, 4, n);
    wait_pin("txquiet_n rising", P_TXQ, 1'b1, 40, n);
    check_level("pa_en disabled", 1'b0, pa_en);
    write_cmd(ADDR_TR, 32'd0);
    wait_pin("pa_tr falling", P_PA_TR, 1'b0, int'(hang) + 8, n);

    @(posedge clk);
    io_phone_tip <= 1'b0;
    wait_pin("pa_tr rising on key", P_PA_TR, 1'b1, 4, n);
    wait_pin("txquiet_n rising on key", P_TXQ, 1'b1, 40, n);
    check_cycles("key keydown delay", tr_interval(1'b0, hang), n);
    @(posedge clk);
    io_cn8 <= 1'b1;
    wait_pin("pa_tr falling on inhibit", P_PA_TR, 1'b0, 4, n);
    check_level("inhibit txquiet_n", 1'b0, txquiet_n);
    check_level("inhibit rfsw_sel", 1'b0, rfsw_sel);
    check_level("inhibit pa_en", 1'b0, pa_en);
    check_level("inhibit led_d3", 1'b0, led_d3);
    @(posedge clk);
    io_phone_tip <= 1'b1;
    write_cmd(ADDR_TR, 32'd1);
    repeat (100) begin
      @(negedge clk);
      check_level("inhibited mox pa_tr", 1'b0, pa_tr);
      check_level("inhibited mox txquiet_n", 1'b0, txquiet_n);
    end
    write_cmd(ADDR_TR, 32'd0);
    @(posedge clk);
    io_cn8 <= 1'b0;
    repeat (4) @(negedge clk);
    check_level("idle after inhibit", 1'b0, pa_tr);

    s.valid = 1'b1;
    for (int i = 0; i < 16; i++) begin
      rng      = xorshift(rng);
      s.sample = 12'(int'(rng % 3071) - 1535);
      check_leds("low sample", s);
    end
    rng      = xorshift(rng);
    mag      = 1536 + int'(rng % 511);
    s.sample = rng[31] ? 12'(-mag) : 12'(mag);
    check_leds("75% sample", s);
    s.sample = 12'(ADC_FULL);
    check_leds("positive full scale", s);
    s.sample = 12'(-ADC_FULL - 1);
    check_leds("negative full scale", s);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
hl2_pkg.sv
cmd_regs.sv
tr_sequencer.sv
ad9866_spi.sv
adc_overload.sv
hermeslite_core.sv
hermeslite.sv
tb_hermeslite.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it
# The exit status is that of the simulator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_hermeslite \
  --Mdir obj_dir -o tb_hermeslite
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_hermeslite
status=$?
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
fi
exit $status
